/* verilog.f */
+incdir+source
source/lcd_bus_pkg.sv
source/lcd_host_pkg.sv
source/lcd_bus_engine.sv
source/lcd_cmd_arb.sv
source/lcd_init_seq.sv
source/lcd_wb_regs.sv
source/lcd_top.sv
test/lcd_bus_monitor.sv
test/tb_lcd_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_lcd_top.sv */
// testbench for lcd_top: clock, reset, Wishbone driver, expected words, checks, watchdog
`timescale 1ns/1ps

module tb_lcd_top;
    import lcd_bus_pkg::*;
    import lcd_host_pkg::*;

    `include "lcd_init_rom.svh"

    localparam int CLK_NS     = 20;
    localparam int DRIVE_NS   = 2;
    localparam int BURST_LEN  = 20;
    localparam int HOST_WORDS = 1 + 4 + BURST_LEN;
    localparam int ACK_LIMIT  = 400;    // cycles, covers a write stalled behind init
    localparam int MIN_GAP    = WR_LOW_CYC + WR_HIGH_CYC;

    logic                  pclk = 1'b0;
    logic                  rst_n;
    wb_req_t               wb_req;
    logic [WB_DAT_W-1:0]   wb_dat;
    logic                  wb_ack;
    logic                  lcd_rst, lcd_cs, lcd_rs, lcd_wr, lcd_bl;
    logic [LCD_DATA_W-1:0] lcd_data;
    lcd_word_t             mon_word;
    logic                  mon_stb, mon_cs_ok;
    logic [7:0]            mon_low, mon_gap;

    lcd_word_t exp_q[$];    // words the panel should still receive
    int        err_cnt = 0;
    int        chk_cnt = 0;
    int        seen_cnt = 0;
    int        ack_cnt = 0;
    int        timing_err = 0;
    int        test_pass = 0;
    int        test_fail = 0;
    int        init_cnt;

    always #(CLK_NS / 2) pclk = ~pclk;

    lcd_top dut0 (.pclk, .rst_n, .wb_req_i(wb_req), .wb_dat_o(wb_dat), .wb_ack_o(wb_ack),
        .lcd_rst_o(lcd_rst), .lcd_cs_o(lcd_cs), .lcd_rs_o(lcd_rs), .lcd_wr_o(lcd_wr),
        .lcd_data_o(lcd_data), .lcd_bl_o(lcd_bl));

    lcd_bus_monitor mon0 (.pclk, .rst_n, .lcd_cs_i(lcd_cs), .lcd_rs_i(lcd_rs),
        .lcd_wr_i(lcd_wr), .lcd_data_i(lcd_data), .word_o(mon_word), .word_stb_o(mon_stb),
        .low_cyc_o(mon_low), .gap_cyc_o(mon_gap), .cs_ok_o(mon_cs_ok));

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // init words in table order, delays emit nothing
    function automatic int load_init_ref();
        lcd_word_t w;
        int        n;
        n = 0;
        for (int i = 0; i < INIT_LEN; i++) begin
            if (INIT_ROM[i].op == OP_END) break;
            if (INIT_ROM[i].op != OP_DELAY) begin
                w.rs    = (INIT_ROM[i].op == OP_DATA);
                w.value = INIT_ROM[i].arg;
                exp_q.push_back(w);
                n++;
            end
        end
        return n;
    endfunction

    function automatic lcd_word_t host_ref(input logic [WB_ADR_W-1:0] adr,
                                           input logic [WB_DAT_W-1:0] dat);
        lcd_word_t w;
        w.rs    = (adr == REG_DATA);
        w.value = dat[LCD_DATA_W-1:0];
        return w;
    endfunction

    function automatic int watchdog_cycles();
        int cyc;
        cyc = 3 + RST_HOLD_CYC + RST_WAIT_CYC + 8 * HOST_WORDS;
        for (int i = 0; i < INIT_LEN; i++) begin
            if (INIT_ROM[i].op == OP_DELAY) cyc += int'(INIT_ROM[i].arg);
            else if (INIT_ROM[i].op != OP_END) cyc += 8;
        end
        return 2 * cyc;
    endfunction

    // called DRIVE_NS after a rising edge, returns at the same point
    task automatic wb_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [WB_DAT_W-1:0] dat, output logic [WB_DAT_W-1:0] rdat);
        int   n;
        logic ack_seen;
        n        = 0;
        ack_seen = 1'b0;
        rdat     = '0;
        wb_req   = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        while (!ack_seen && n < ACK_LIMIT) begin
            @(negedge pclk);
            n++;
            ack_seen = wb_ack;
        end
        if (ack_seen) rdat = wb_dat;
        else begin
            err_cnt++;
            $display("no ack for register %h within %0d cycles", adr, ACK_LIMIT);
        end
        @(posedge pclk);
        #DRIVE_NS;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [WB_DAT_W-1:0] dat);
        logic [WB_DAT_W-1:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [WB_DAT_W-1:0] rdat);
        wb_cycle(1'b0, adr, '0, rdat);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < ACK_LIMIT) begin
            @(negedge pclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected panel words never appeared", exp_q.size());
        end
        @(posedge pclk);
        #DRIVE_NS;
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            test_pass++;
            $display("test %0d %s: ok", num, name);
        end else begin
            test_fail++;
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    // acks on the bus, and no wr pulse while the panel is held in reset
    always @(negedge pclk) begin
        if (wb_ack) ack_cnt++;
        if (rst_n && !lcd_wr) begin
            check(32'(lcd_rst), 32'd1, "panel out of reset during a wr pulse");
        end
    end

    // compare each captured panel word with the head of the expected list
    always @(posedge pclk) begin
        lcd_word_t exp_w;
        int        e0;
        if (mon_stb) begin
            seen_cnt++;
            e0 = err_cnt;
            check(32'(mon_low), 32'(WR_LOW_CYC), "wr low pulse length");
            check(32'(mon_cs_ok), 32'd1, "cs low across the write pulse");
            check(32'(int'(mon_gap) >= MIN_GAP), 32'd1, "spacing of wr falling edges");
            timing_err += err_cnt - e0;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected panel word %h at %0t", mon_word, $time);
            end else begin
                exp_w = exp_q.pop_front();
                check(32'(mon_word), 32'(exp_w), "panel word");
            end
        end
    end

    initial begin
        #(watchdog_cycles() * CLK_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [WB_DAT_W-1:0] rd;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_DAT_W-1:0] rnd;
        logic [WB_ADR_W-1:0] adr;
        int                  e0;
        int                  acks0;
        void'($urandom(32'h1e6b));
        rst_n    = 1'b0;
        wb_req   = '0;
        init_cnt = load_init_ref();
        repeat (3) @(posedge pclk);
        #DRIVE_NS;
        rst_n = 1'b1;

        e0 = err_cnt;
        check(32'(lcd_cs), 32'd1, "cs idle after reset");
        check(32'(lcd_wr), 32'd1, "wr idle after reset");
        check(32'(lcd_rst), 32'd0, "panel reset held");
        check(32'(lcd_bl), 32'd0, "backlight off after reset");
        wb_read(REG_STATUS, rd);
        check(32'(rd[STAT_INIT_DONE_BIT]), 32'd0, "init_done after reset");
        report_test(1, "after reset", err_cnt - e0);

        // host command issued during init stalls until the table is played
        e0 = err_cnt;
        exp_q.push_back(host_ref(REG_CMD, 32'hA5A5_002C));
        wb_write(REG_CMD, 32'hA5A5_002C);
        check(32'(seen_cnt), 32'(init_cnt), "init words on panel before host ack");
        wb_read(REG_STATUS, rd);
        check(32'(rd[STAT_INIT_DONE_BIT]), 32'd1, "init_done after playback");
        report_test(2, "init playback", err_cnt - e0);

        e0 = err_cnt;
        exp_q.push_back(host_ref(REG_CMD, 32'h0000_002A));
        wb_write(REG_CMD, 32'h0000_002A);
        exp_q.push_back(host_ref(REG_DATA, 32'h1234_F800));
        wb_write(REG_DATA, 32'h1234_F800);
        exp_q.push_back(host_ref(REG_DATA, 32'hFFFF_07E0));
        wb_write(REG_DATA, 32'hFFFF_07E0);
        exp_q.push_back(host_ref(REG_CMD, 32'h8000_002C));
        wb_write(REG_CMD, 32'h8000_002C);
        wait_drain();
        report_test(3, "host writes", err_cnt - e0);

        e0    = err_cnt;
        acks0 = ack_cnt;
        for (int i = 0; i < BURST_LEN; i++) begin
            rnd = $urandom();
            dat = $urandom();
            adr = rnd[0] ? REG_DATA : REG_CMD;
            exp_q.push_back(host_ref(adr, dat));
            wb_write(adr, dat);
        end
        wait_drain();
        check(32'(ack_cnt - acks0), 32'(BURST_LEN), "acks for the burst");
        report_test(4, "back-pressure burst", err_cnt - e0);
        report_test(5, "write-cycle timing", timing_err);

        e0 = err_cnt;
        wb_write(REG_CTRL, 32'd1);
        check(32'(lcd_bl), 32'd1, "backlight on");
        wb_read(REG_CTRL, rd);
        check(rd, 32'd1, "CTRL readback");
        wb_write(REG_CTRL, 32'd0);
        check(32'(lcd_bl), 32'd0, "backlight off");
        wb_read(REG_CMD, rd);
        check(rd, 32'd0, "CMD reads as zero");
        report_test(6, "registers", err_cnt - e0);

        repeat (10) @(negedge pclk);
        check(32'(exp_q.size()), 32'd0, "expected words left over");
        check(32'(seen_cnt), 32'(init_cnt + HOST_WORDS), "panel word count");
        $display("tests: %0d passed, %0d failed; checks: %0d; errors: %0d",
                 test_pass, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/lcd_bus_monitor.sv */
// panel bus monitor: word capture at the wr rising edge, wr pulse length and spacing
`timescale 1ns/1ps

module lcd_bus_monitor (
    input  logic                               pclk,
    input  logic                               rst_n,
    input  logic                               lcd_cs_i,
    input  logic                               lcd_rs_i,
    input  logic                               lcd_wr_i,
    input  logic [lcd_bus_pkg::LCD_DATA_W-1:0] lcd_data_i,
    output lcd_bus_pkg::lcd_word_t             word_o,
    output logic                               word_stb_o,
    output logic [7:0]                         low_cyc_o,   // wr low length of this word
    output logic [7:0]                         gap_cyc_o,   // cycles since previous wr fall
    output logic                               cs_ok_o
);
    import lcd_bus_pkg::*;

    logic       wr_prev;
    logic [7:0] low_cnt;
    logic [7:0] gap_cnt;
    logic [7:0] fall_gap;
    logic       cs_held;

    // sampled mid-cycle, where the panel lines have settled
    always @(negedge pclk) begin
        if (!rst_n) begin
            wr_prev    <= 1'b1;
            low_cnt    <= '0;
            gap_cnt    <= '1;    // saturated, no earlier fall
            fall_gap   <= '1;
            cs_held    <= 1'b1;
            word_o     <= '0;
            word_stb_o <= 1'b0;
            low_cyc_o  <= '0;
            gap_cyc_o  <= '0;
            cs_ok_o    <= 1'b0;
        end else begin
            word_stb_o <= 1'b0;
            gap_cnt    <= (gap_cnt == '1) ? gap_cnt : gap_cnt + 1'b1;
            if (!lcd_wr_i && wr_prev) begin    // falling edge
                fall_gap <= gap_cnt;
                gap_cnt  <= 8'd1;
                low_cnt  <= 8'd1;
                cs_held  <= !lcd_cs_i;
            end else if (!lcd_wr_i) begin
                low_cnt <= low_cnt + 1'b1;
                cs_held <= cs_held && !lcd_cs_i;
            end else if (!wr_prev) begin
                // rising edge, the panel latches the word here
                word_o     <= '{rs: lcd_rs_i, value: lcd_data_i};
                word_stb_o <= 1'b1;
                low_cyc_o  <= low_cnt;
                gap_cyc_o  <= fall_gap;
                cs_ok_o    <= cs_held && !lcd_cs_i;
            end
            wr_prev <= lcd_wr_i;
        end
    end

endmodule

/* source/lcd_top.sv */
// TFT panel controller top: Wishbone regs, init sequencer, source arbiter, 8080 bus engine
`timescale 1ns/1ps

module lcd_top (
    input  logic                                  pclk,
    input  logic                                  rst_n,
    input  lcd_host_pkg::wb_req_t                 wb_req_i,
    output logic [lcd_host_pkg::WB_DAT_W-1:0]     wb_dat_o,
    output logic                                  wb_ack_o,
    output logic                                  lcd_rst_o,
    output logic                                  lcd_cs_o,
    output logic                                  lcd_rs_o,
    output logic                                  lcd_wr_o,
    output logic [lcd_bus_pkg::LCD_DATA_W-1:0]    lcd_data_o,
    output logic                                  lcd_bl_o
);
    import lcd_bus_pkg::*;

    lcd_word_t host_word, init_word, bus_word;
    logic      host_valid, host_ready, init_valid, init_ready, bus_valid, bus_ready;
    logic      init_done, bus_busy;

    lcd_wb_regs u_regs (.pclk, .rst_n, .wb_req_i, .wb_dat_o, .wb_ack_o,
        .host_word_o(host_word), .host_valid_o(host_valid), .host_ready_i(host_ready),
        .init_done_i(init_done), .bus_busy_i(bus_busy), .lcd_bl_o);

    lcd_init_seq u_init (.pclk, .rst_n, .init_word_o(init_word), .init_valid_o(init_valid),
        .init_ready_i(init_ready), .lcd_rst_o, .init_done_o(init_done));

    lcd_cmd_arb u_arb (.pclk, .rst_n, .init_done_i(init_done),
        .init_word_i(init_word), .init_valid_i(init_valid), .init_ready_o(init_ready),
        .host_word_i(host_word), .host_valid_i(host_valid), .host_ready_o(host_ready),
        .bus_word_o(bus_word), .bus_valid_o(bus_valid), .bus_ready_i(bus_ready));

    lcd_bus_engine u_bus (.pclk, .rst_n, .bus_word_i(bus_word), .bus_valid_i(bus_valid),
        .bus_ready_o(bus_ready), .busy_o(bus_busy), .lcd_cs_o, .lcd_rs_o, .lcd_wr_o,
        .lcd_data_o);

endmodule

/* source/lcd_wb_regs.sv */
// Wishbone classic slave: CMD/DATA word push, CTRL backlight, STATUS readback
`timescale 1ns/1ps

module lcd_wb_regs (
    input  logic                              pclk,
    input  logic                              rst_n,
    input  lcd_host_pkg::wb_req_t             wb_req_i,
    output logic [lcd_host_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                              wb_ack_o,
    output lcd_bus_pkg::lcd_word_t            host_word_o,
    output logic                              host_valid_o,
    input  logic                              host_ready_i,
    input  logic                              init_done_i,
    input  logic                              bus_busy_i,
    output logic                              lcd_bl_o
);
    import lcd_bus_pkg::*;
    import lcd_host_pkg::*;

    reg_sel_t            sel;
    logic                req;
    logic                word_wr;    // CMD or DATA write
    logic                ack_q;      // reads and CTRL/STATUS writes
    logic                bl_q;
    logic                host_valid_q;
    lcd_word_t           host_word_q;
    logic [WB_DAT_W-1:0] status;
    logic [WB_DAT_W-1:0] rd_val;
    logic [WB_DAT_W-1:0] rd_dat_q;

    always_comb begin
        sel = SEL_STATUS;
        case ({wb_req_i.adr[WB_ADR_W-1:2], 2'b00})
            REG_CMD:    sel = SEL_CMD;
            REG_DATA:   sel = SEL_DATA;
            REG_CTRL:   sel = SEL_CTRL;
            REG_STATUS: sel = SEL_STATUS;
            default:    sel = SEL_STATUS;
        endcase
    end

    assign req     = wb_req_i.cyc && wb_req_i.stb;
    assign word_wr = req && wb_req_i.we && (sel == SEL_CMD || sel == SEL_DATA);

    always_comb begin
        status                     = '0;
        status[STAT_INIT_DONE_BIT] = init_done_i;
        status[STAT_BUSY_BIT]      = bus_busy_i;
        rd_val                     = '0;    // CMD/DATA read as zero
        if (sel == SEL_CTRL) rd_val[CTRL_BL_BIT] = bl_q;
        if (sel == SEL_STATUS) rd_val = status;
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            ack_q        <= 1'b0;
            bl_q         <= 1'b0;
            host_valid_q <= 1'b0;
        end else begin
            ack_q <= req && !word_wr && !ack_q;
            if (req && wb_req_i.we && sel == SEL_CTRL && !ack_q) begin
                bl_q <= wb_req_i.dat[CTRL_BL_BIT];
            end
            if (host_valid_q && host_ready_i) host_valid_q <= 1'b0;
            else if (word_wr && !host_valid_q) host_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge pclk) begin
        rd_dat_q <= (req && !wb_req_i.we) ? rd_val : '0;
        if (word_wr && !host_valid_q) begin
            host_word_q <= '{rs: (sel == SEL_DATA), value: wb_req_i.dat[LCD_DATA_W-1:0]};
        end
    end

    // word writes ack in the cycle the arbiter takes them
    assign wb_ack_o     = ack_q || (host_valid_q && host_ready_i);
    assign wb_dat_o     = rd_dat_q;
    assign host_word_o  = host_word_q;
    assign host_valid_o = host_valid_q;
    assign lcd_bl_o     = bl_q;

    a_ack_single: assert property (@(posedge pclk) disable iff (!rst_n)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* source/lcd_init_seq.sv */
// panel reset pulse timing and playback of the init table
`timescale 1ns/1ps

module lcd_init_seq (
    input  logic                   pclk,
    input  logic                   rst_n,
    output lcd_bus_pkg::lcd_word_t init_word_o,
    output logic                   init_valid_o,
    input  logic                   init_ready_i,
    output logic                   lcd_rst_o,
    output logic                   init_done_o
);
    import lcd_bus_pkg::*;

    `include "lcd_init_rom.svh"

    typedef enum logic [2:0] {
        ST_RST_HOLD,
        ST_RST_WAIT,
        ST_FETCH,
        ST_EMIT,
        ST_DELAY,
        ST_DONE
    } seq_state_t;

    seq_state_t            state_q;
    logic [LCD_DATA_W-1:0] cnt_q;       // reset phases and delays
    logic [INIT_IDX_W-1:0] idx_q;
    init_entry_t           entry_q;
    init_entry_t           rom_entry;

    assign rom_entry = INIT_ROM[idx_q];

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q <= ST_RST_HOLD;
            cnt_q   <= '0;
            idx_q   <= '0;
        end else begin
            case (state_q)
                ST_RST_HOLD: begin
                    if (cnt_q == LCD_DATA_W'(RST_HOLD_CYC - 1)) begin
                        state_q <= ST_RST_WAIT;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_RST_WAIT: begin
                    if (cnt_q == LCD_DATA_W'(RST_WAIT_CYC - 1)) state_q <= ST_FETCH;
                    else cnt_q <= cnt_q + 1'b1;
                end
                ST_FETCH: begin
                    case (rom_entry.op)
                        OP_CMD, OP_DATA: state_q <= ST_EMIT;
                        OP_DELAY: begin
                            state_q <= ST_DELAY;
                            cnt_q   <= LCD_DATA_W'(1);
                        end
                        default: state_q <= ST_DONE;    // OP_END
                    endcase
                    if (rom_entry.op != OP_END) idx_q <= idx_q + 1'b1;
                end
                ST_EMIT: if (init_ready_i) state_q <= ST_FETCH;
                ST_DELAY: begin
                    if (cnt_q >= entry_q.arg) state_q <= ST_FETCH;
                    else cnt_q <= cnt_q + 1'b1;
                end
                default: state_q <= ST_DONE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (state_q == ST_FETCH) entry_q <= rom_entry;
    end

    assign init_word_o  = '{rs: (entry_q.op == OP_DATA), value: entry_q.arg};
    assign init_valid_o = (state_q == ST_EMIT);
    assign lcd_rst_o    = (state_q != ST_RST_HOLD);
    assign init_done_o  = (state_q == ST_DONE);

    // panel has been out of reset for the whole wait time before any word
    a_rst_before_word: assert property (@(posedge pclk) disable iff (!rst_n)
        init_valid_o |-> lcd_rst_o && $past(lcd_rst_o, RST_WAIT_CYC));

endmodule

/* source/lcd_cmd_arb.sv */
// source select between init and host words, one-entry buffer toward the bus engine
`timescale 1ns/1ps

module lcd_cmd_arb (
    input  logic                   pclk,
    input  logic                   rst_n,
    input  logic                   init_done_i,
    input  lcd_bus_pkg::lcd_word_t init_word_i,
    input  logic                   init_valid_i,
    output logic                   init_ready_o,
    input  lcd_bus_pkg::lcd_word_t host_word_i,
    input  logic                   host_valid_i,
    output logic                   host_ready_o,
    output lcd_bus_pkg::lcd_word_t bus_word_o,
    output logic                   bus_valid_o,
    input  logic                   bus_ready_i
);
    import lcd_bus_pkg::*;

    lcd_word_t buf_word_q;
    logic      buf_valid_q;
    logic      take;         // buffer free or draining this cycle
    lcd_word_t src_word;
    logic      src_valid;

    assign take         = !buf_valid_q || bus_ready_i;
    assign init_ready_o = take && !init_done_i;
    assign host_ready_o = take && init_done_i;
    assign src_valid    = init_done_i ? host_valid_i : init_valid_i;
    assign src_word     = init_done_i ? host_word_i : init_word_i;

    always_ff @(posedge pclk) begin
        if (!rst_n) buf_valid_q <= 1'b0;
        else if (take) buf_valid_q <= src_valid;
    end

    always_ff @(posedge pclk) begin
        if (take && src_valid) buf_word_q <= src_word;
    end

    assign bus_word_o  = buf_word_q;
    assign bus_valid_o = buf_valid_q;

    // bus ownership passes to the host once and never returns
    a_one_owner: assert property (@(posedge pclk) disable iff (!rst_n)
        host_ready_o |-> !init_ready_o ##1 !init_ready_o);
    // no init word is left stranded when the sequencer reports done
    a_init_drained: assert property (@(posedge pclk) disable iff (!rst_n)
        init_done_i |-> !init_valid_i);

endmodule

/* source/lcd_bus_engine.sv */
// 8080 parallel write-cycle generator: cs, rs, wr and 16-bit data toward the panel
`timescale 1ns/1ps

module lcd_bus_engine (
    input  logic                               pclk,
    input  logic                               rst_n,
    input  lcd_bus_pkg::lcd_word_t             bus_word_i,
    input  logic                               bus_valid_i,
    output logic                               bus_ready_o,
    output logic                               busy_o,
    output logic                               lcd_cs_o,
    output logic                               lcd_rs_o,
    output logic                               lcd_wr_o,
    output logic [lcd_bus_pkg::LCD_DATA_W-1:0] lcd_data_o
);
    import lcd_bus_pkg::*;

    bus_state_t         state_q;
    logic [PHASE_W-1:0] phase_q;
    lcd_word_t          word_q;
    logic               low_last;
    logic               high_last;

    assign low_last  = (phase_q == PHASE_W'(WR_LOW_CYC - 1));
    assign high_last = (phase_q == PHASE_W'(WR_HIGH_CYC - 1));
    // the last high cycle may take the next word, 4 cycles per word
    assign bus_ready_o = (state_q == BUS_IDLE) || (state_q == BUS_WR_HIGH && high_last);

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state_q <= BUS_IDLE;
            phase_q <= '0;
        end else begin
            case (state_q)
                BUS_IDLE: if (bus_valid_i) state_q <= BUS_WR_LOW;
                BUS_WR_LOW: begin
                    if (low_last) begin
                        state_q <= BUS_WR_HIGH;
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                end
                BUS_WR_HIGH: begin
                    if (high_last) begin
                        state_q <= bus_valid_i ? BUS_WR_LOW : BUS_IDLE;
                        phase_q <= '0;
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                end
                default: state_q <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (bus_valid_i && bus_ready_o) word_q <= bus_word_i;
    end

    assign busy_o     = (state_q != BUS_IDLE);
    assign lcd_cs_o   = (state_q == BUS_IDLE);   // low across the whole cycle
    assign lcd_wr_o   = (state_q != BUS_WR_LOW);
    assign lcd_rs_o   = lcd_cs_o | word_q.rs;    // idles high
    assign lcd_data_o = word_q.value;

    // wr rises while cs is still low, so the panel latch edge is inside cs
    a_wr_in_cs: assert property (@(posedge pclk) disable iff (!rst_n)
        !lcd_wr_o |-> !lcd_cs_o ##1 !lcd_cs_o);

endmodule

/* source/lcd_host_pkg.sv */
// Wishbone request type, register map and CTRL/STATUS bit positions
package lcd_host_pkg;

    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 32;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // byte addresses
    localparam logic [WB_ADR_W-1:0] REG_CMD    = 4'h0;
    localparam logic [WB_ADR_W-1:0] REG_DATA   = 4'h4;
    localparam logic [WB_ADR_W-1:0] REG_CTRL   = 4'h8;
    localparam logic [WB_ADR_W-1:0] REG_STATUS = 4'hC;

    localparam int CTRL_BL_BIT        = 0;
    localparam int STAT_INIT_DONE_BIT = 0;
    localparam int STAT_BUSY_BIT      = 1;

    typedef enum logic [1:0] {SEL_CMD, SEL_DATA, SEL_CTRL, SEL_STATUS} reg_sel_t;

endpackage

/* source/lcd_bus_pkg.sv */
// panel word type, write-cycle timing, reset timing, init table types and bus FSM states
package lcd_bus_pkg;

    localparam int LCD_DATA_W = 16;

    typedef struct packed {
        logic                  rs;     // 0 command, 1 data
        logic [LCD_DATA_W-1:0] value;
    } lcd_word_t;

    // 8080 write cycle, in pclk cycles
    localparam int WR_LOW_CYC  = 2;
    localparam int WR_HIGH_CYC = 2;
    localparam int PHASE_W     =
        $clog2((WR_LOW_CYC > WR_HIGH_CYC ? WR_LOW_CYC : WR_HIGH_CYC) + 1);

    // panel reset pulse and settle time
    localparam int RST_HOLD_CYC = 40;
    localparam int RST_WAIT_CYC = 40;

    typedef enum logic [1:0] {
        OP_CMD,
        OP_DATA,
        OP_DELAY,    // arg is a wait in cycles
        OP_END
    } init_op_t;

    typedef struct packed {
        init_op_t              op;
        logic [LCD_DATA_W-1:0] arg;
    } init_entry_t;

    localparam int INIT_LEN   = 16;
    localparam int INIT_IDX_W = $clog2(INIT_LEN);

    typedef enum logic [1:0] {BUS_IDLE, BUS_WR_LOW, BUS_WR_HIGH} bus_state_t;

endpackage

/* source/lcd_init_rom.svh */
// panel init table: opcode and 16-bit argument per entry

localparam lcd_bus_pkg::init_entry_t INIT_ROM [lcd_bus_pkg::INIT_LEN] = '{
    '{lcd_bus_pkg::OP_CMD,   16'h0001},    // soft reset
    '{lcd_bus_pkg::OP_DELAY, 16'd50},
    '{lcd_bus_pkg::OP_CMD,   16'h0011},    // sleep out
    '{lcd_bus_pkg::OP_DELAY, 16'd60},
    '{lcd_bus_pkg::OP_CMD,   16'h003A},    // pixel format
    '{lcd_bus_pkg::OP_DATA,  16'h0055},    // 16 bpp
    '{lcd_bus_pkg::OP_CMD,   16'h0036},    // memory access ctrl
    '{lcd_bus_pkg::OP_DATA,  16'h0048},
    '{lcd_bus_pkg::OP_CMD,   16'h002A},    // column window
    '{lcd_bus_pkg::OP_DATA,  16'h0000},
    '{lcd_bus_pkg::OP_DATA,  16'h0000},
    '{lcd_bus_pkg::OP_DATA,  16'h0001},
    '{lcd_bus_pkg::OP_DATA,  16'h00DF},
    '{lcd_bus_pkg::OP_CMD,   16'h0029},    // display on
    '{lcd_bus_pkg::OP_DELAY, 16'd10},
    '{lcd_bus_pkg::OP_END,   16'h0000}
};
